// File: src/agnus_pkg.sv
// ------------------------------------------------
// chip bus core shared types: bus widths, register
// offsets, bus owner enum and the request, grant,
// enable and cpu structs
// ------------------------------------------------

`default_nettype none

package agnus_pkg;

  // ------------------------------------------------
  // widths
  localparam int chip_addr_w = 20; // word address, chip address bits 20..1
  localparam int reg_addr_w  = 8;  // 256 word register bank
  localparam int data_w      = 16;
  localparam int dmacon_w    = 13; // stored DMACON bits 12..0

  // ------------------------------------------------
  // register word offsets
  localparam logic [reg_addr_w-1:0] reg_dmacon  = 8'h4b; // DMACON write (byte 0x096)
  localparam logic [reg_addr_w-1:0] reg_dmaconr = 8'h01; // DMACONR read (byte 0x002)
  localparam logic [reg_addr_w-1:0] reg_idle    = 8'hff; // no register selected

  // who holds the chip bus in the current slot
  typedef enum logic [2:0] {
    cpu      = 3'd0, // no dma, cpu gets the slot
    disk     = 3'd1,
    refresh  = 3'd2,
    audio    = 3'd3,
    bitplane = 3'd4,
    sprite   = 3'd5,
    copper   = 3'd6,
    blitter  = 3'd7
  } bus_owner_t;

  // one dma engine's request to the arbiter
  typedef struct packed {
    logic                   req;         // request or slot-use flag
    logic                   we;          // memory write
    logic [chip_addr_w-1:0] address;     // chip ram word address
    logic [reg_addr_w-1:0]  reg_address; // destination register
  } dma_chan_t;

  // what the arbiter puts on the chip bus
  typedef struct packed {
    bus_owner_t             owner;
    logic [chip_addr_w-1:0] address;
    logic [reg_addr_w-1:0]  reg_address;
    logic                   dbr;         // agnus holds the data bus
    logic                   dbwe;        // dma memory write
    logic                   cpu_custom;  // cpu owns chip ram and registers
  } bus_grant_t;

  // decoded DMACON enables, master bit already applied
  typedef struct packed {
    logic bplen;
    logic copen;
    logic blten;
    logic spren;
    logic bltpri; // blitter nasty
  } dma_enables_t;

  // cpu side of the register bank
  typedef struct packed {
    logic                  aen;     // register bank select
    logic                  rd;
    logic                  hwr;     // high byte write
    logic                  lwr;     // low byte write
    logic [reg_addr_w-1:0] address;
    logic [data_w-1:0]     data;
  } cpu_bus_t;

endpackage

`default_nettype wire

// File: src/beam_timer.sv
// ------------------------------------------------
// horizontal slot counter with colour clock,
// refresh slot decode and line strobes
// ------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module beam_timer #(
  parameter int unsigned line_len = 454 // slots per line, pal
) (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       clk7_en,       // one dma slot per enable
  output logic      [8:0] hpos,          // slot position in the line
  output logic            cck,           // colour clock, odd slots go to the chipset
  output logic            refresh,       // memory refresh slot
  output logic            sol,           // last slot of the line
  output logic            strhor_denise,
  output logic            strhor_paula
);

  // ------------------------------------------------
  // fixed slot positions
  localparam logic [8:0] hpos_last   = 9'(line_len - 1);
  localparam logic [8:0] hpos_denise = 9'd11; // 6*2-1, compensates denise pipeline delay
  localparam logic [8:0] hpos_paula  = 9'd13; // 6*2+1

  logic line_end; // counter sits on the last slot

  assign line_end = (hpos == hpos_last);

  // ------------------------------------------------
  // slot counter
  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '0;
    end else if (clk7_en) begin
      if (line_end) begin
        hpos <= '0; // wrap to next line
      end else begin
        hpos <= hpos + 9'd1;
      end
    end
  end

  // ------------------------------------------------
  // slot decode
  assign cck = hpos[0]; // odd slots

  // refresh takes the odd slots 1, 3, 5 and 7
  assign refresh = (hpos[8:3] == 6'd0) && hpos[0];

  assign sol           = line_end;
  assign strhor_denise = (hpos == hpos_denise); // no vpos condition here
  assign strhor_paula  = (hpos == hpos_paula);

  // ------------------------------------------------
  // line length check
  // counter must wrap before it gets to line_len
  hpos_in_line: assert property (
    @(posedge clk) disable iff (reset)
    hpos < line_len
  );

endmodule

`default_nettype wire

// File: src/dma_control.sv
// ------------------------------------------------
// DMACON register: set/clear write, channel
// enable decode and DMACONR read-back
// ------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module dma_control (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic                              clk7_en,
  input  wire logic [agnus_pkg::reg_addr_w-1:0]  reg_address, // decoded bus register address
  input  wire logic [agnus_pkg::data_w-1:0]      data_in,     // cpu write data
  input  wire logic                              blit_busy,   // blitter status flags
  input  wire logic                              blit_zero,
  output agnus_pkg::dma_enables_t                enables,
  output logic      [agnus_pkg::data_w-1:0]      data_out     // DMACONR or zero
);

  // ------------------------------------------------
  // DMACON bit positions
  localparam int bit_setclr = 15; // 1 sets, 0 clears the written ones
  localparam int bit_bltpri = 10;
  localparam int bit_dmaen  = 9;  // master enable
  localparam int bit_bplen  = 8;
  localparam int bit_copen  = 7;
  localparam int bit_blten  = 6;
  localparam int bit_spren  = 5;

  logic [agnus_pkg::dmacon_w-1:0] dmacon;     // stored control bits
  logic [agnus_pkg::dmacon_w-1:0] wr_bits;    // written mask
  logic                           wr_dmacon;  // write strobe this slot

  assign wr_dmacon = clk7_en && (reg_address == agnus_pkg::reg_dmacon);
  assign wr_bits   = data_in[agnus_pkg::dmacon_w-1:0];

  // ------------------------------------------------
  // set/clear write
  always_ff @(posedge clk) begin
    if (reset) begin
      dmacon <= '0;
    end else if (wr_dmacon) begin
      if (data_in[bit_setclr]) begin
        dmacon <= dmacon | wr_bits;  // or in
      end else begin
        dmacon <= dmacon & ~wr_bits; // and out
      end
    end
  end

  // ------------------------------------------------
  // enable decode, each channel needs the master bit too
  assign enables.bplen  = dmacon[bit_bplen] & dmacon[bit_dmaen];
  assign enables.copen  = dmacon[bit_copen] & dmacon[bit_dmaen];
  assign enables.blten  = dmacon[bit_blten] & dmacon[bit_dmaen];
  assign enables.spren  = dmacon[bit_spren] & dmacon[bit_dmaen];
  assign enables.bltpri = dmacon[bit_bltpri]; // not gated by master

  // read-back, or'd onto the shared read bus so zero when not selected
  always_comb begin
    if (reg_address == agnus_pkg::reg_dmaconr) begin
      data_out = {1'b0, blit_busy, blit_zero, dmacon};
    end else begin
      data_out = '0;
    end
  end

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
// ------------------------------------------------
// fixed-priority chip bus arbiter with blitter
// slowdown counter and cpu register decode
// ------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module bus_arbiter #(
  parameter int unsigned bls_cnt_max = 3 // cpu misses before the blitter backs off
) (
  input  wire logic                    clk,
  input  wire logic                    clk7_en,
  input  wire logic                    cck,      // colour clock, low on even slots
  input  wire logic                    refresh,  // refresh slot
  input  agnus_pkg::dma_enables_t      enables,
  input  wire logic                    bls,      // cpu is waiting for the bus
  input  agnus_pkg::cpu_bus_t          cpu,
  input  agnus_pkg::dma_chan_t         disk,     // slot-use flag channels
  input  agnus_pkg::dma_chan_t         audio,
  input  agnus_pkg::dma_chan_t         bitplane,
  input  agnus_pkg::dma_chan_t         sprite,   // req/ack channels
  input  agnus_pkg::dma_chan_t         copper,
  input  agnus_pkg::dma_chan_t         blitter,
  output agnus_pkg::bus_grant_t        grant,
  output logic                         ack_spr,
  output logic                         ack_cop,
  output logic                         ack_blt,
  output logic                         ena_cop,  // no higher channel blocks the copper
  output logic                         ena_blt   // no higher channel blocks the blitter
);

  localparam int cnt_w = $clog2(bls_cnt_max + 1);

  // refresh looks like a read cycle with no target
  localparam agnus_pkg::dma_chan_t ref_chan = '{
    req:         1'b1,
    we:          1'b0,
    address:     '0,
    reg_address: agnus_pkg::reg_idle
  };

  logic [cnt_w-1:0]                 bls_cnt;  // memory cycles the cpu has missed
  logic                             bls_full; // blitter must let the cpu in
  logic [agnus_pkg::reg_addr_w-1:0] reg_address_cpu;

  // channels that take the current slot
  logic dma_dsk;
  logic dma_aud;
  logic dma_bpl;
  logic dma_spr;
  logic dma_cop;
  logic dma_blt;

  // grant for one dma channel, we_ok only for disk and blitter
  function automatic agnus_pkg::bus_grant_t chan_grant(
    input agnus_pkg::bus_owner_t owner,
    input agnus_pkg::dma_chan_t  chan,
    input logic                  we_ok
  );
    agnus_pkg::bus_grant_t g;
    g.owner       = owner;
    g.address     = chan.address;
    g.reg_address = chan.reg_address;
    g.dbr         = 1'b1;           // agnus drives the data bus
    g.dbwe        = chan.we & we_ok;
    g.cpu_custom  = 1'b0;
    return g;
  endfunction

  // ------------------------------------------------
  // request qualification
  assign bls_full = (bls_cnt == cnt_w'(bls_cnt_max));

  assign dma_dsk = disk.req;
  assign dma_aud = audio.req;
  assign dma_bpl = bitplane.req & enables.bplen; // engine gating done here
  assign dma_spr = sprite.req & enables.spren;
  assign dma_cop = copper.req & enables.copen;
  assign dma_blt = blitter.req & enables.blten & ~bls_full;

  // cpu only selects a register during an actual access
  assign reg_address_cpu = (cpu.aen && (cpu.rd || cpu.hwr || cpu.lwr)) ?
                           cpu.address : agnus_pkg::reg_idle;

  // copper slots can only be stolen by bitplanes
  assign ena_cop = ~dma_bpl;
  assign ena_blt = ~(dma_dsk | refresh | dma_aud | dma_bpl | dma_spr | dma_cop) & ~bls_full;

  // ------------------------------------------------
  // priority mux, first match wins
  always_comb begin
    ack_spr = 1'b0;
    ack_cop = 1'b0;
    ack_blt = 1'b0;
    if (dma_dsk) begin
      grant = chan_grant(agnus_pkg::disk, disk, 1'b1);
    end else if (refresh) begin
      grant = chan_grant(agnus_pkg::refresh, ref_chan, 1'b0);
    end else if (dma_aud) begin
      grant = chan_grant(agnus_pkg::audio, audio, 1'b0);
    end else if (dma_bpl) begin
      grant = chan_grant(agnus_pkg::bitplane, bitplane, 1'b0);
    end else if (dma_spr) begin
      grant   = chan_grant(agnus_pkg::sprite, sprite, 1'b0);
      ack_spr = 1'b1;
    end else if (dma_cop) begin
      grant   = chan_grant(agnus_pkg::copper, copper, 1'b0);
      ack_cop = 1'b1;
    end else if (dma_blt) begin
      grant   = chan_grant(agnus_pkg::blitter, blitter, 1'b1);
      ack_blt = 1'b1;
    end else begin
      // slot free for the cpu
      grant.owner       = agnus_pkg::cpu;
      grant.address     = '0;
      grant.reg_address = reg_address_cpu;
      grant.dbr         = 1'b0;
      grant.dbwe        = 1'b0;
      grant.cpu_custom  = 1'b1;
    end
  end

  // ------------------------------------------------
  // blitter slowdown, counts on even slots only
  always_ff @(posedge clk) begin
    if (clk7_en && !cck) begin
      if (!bls || enables.bltpri) begin
        bls_cnt <= '0; // cpu got in or nasty mode
      end else if (!bls_full) begin
        bls_cnt <= bls_cnt + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // handshake checks, held off until the counter has settled
  ack_onehot: assert property (
    @(posedge clk) disable iff ($isunknown(bls_cnt))
    $onehot0({ack_spr, ack_cop, ack_blt})
  );

  ack_spr_req: assert property (
    @(posedge clk) disable iff ($isunknown(bls_cnt))
    $rose(ack_spr) |-> sprite.req
  );

  ack_cop_req: assert property (
    @(posedge clk) disable iff ($isunknown(bls_cnt))
    $rose(ack_cop) |-> copper.req
  );

  ack_blt_req: assert property (
    @(posedge clk) disable iff ($isunknown(bls_cnt))
    $rose(ack_blt) |-> blitter.req
  );

endmodule

`default_nettype wire

// File: src/agnus_bus.sv
// ------------------------------------------------
// chip bus core top level: slot timer, DMACON
// and bus arbiter
// ------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module agnus_bus #(
  parameter int unsigned line_len    = 454, // pal line in slots
  parameter int unsigned bls_cnt_max = 3
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          clk7_en,      // slot enable
  input  wire logic                          bls,          // blitter slowdown request
  input  agnus_pkg::cpu_bus_t                cpu,
  input  agnus_pkg::dma_chan_t               disk,
  input  agnus_pkg::dma_chan_t               audio,
  input  agnus_pkg::dma_chan_t               bitplane,
  input  agnus_pkg::dma_chan_t               sprite,
  input  agnus_pkg::dma_chan_t               copper,
  input  agnus_pkg::dma_chan_t               blitter,
  input  wire logic                          blit_busy,
  input  wire logic                          blit_zero,
  output agnus_pkg::bus_grant_t              grant,
  output logic      [agnus_pkg::data_w-1:0]  data_out,     // register read data
  output logic      [8:0]                    hpos,
  output logic                               cck,
  output logic                               sol,
  output logic                               strhor_denise,
  output logic                               strhor_paula,
  output logic                               ack_spr,
  output logic                               ack_cop,
  output logic                               ack_blt,
  output logic                               ena_cop,
  output logic                               ena_blt
);

  logic                    refresh; // refresh slot, timer to arbiter
  agnus_pkg::dma_enables_t enables; // decoded DMACON

  // ------------------------------------------------
  // horizontal slot timer
  beam_timer #(
    .line_len      (line_len)
  ) beam_timer_inst (
    .clk           (clk),
    .reset         (reset),
    .clk7_en       (clk7_en),
    .hpos          (hpos),
    .cck           (cck),
    .refresh       (refresh),
    .sol           (sol),
    .strhor_denise (strhor_denise),
    .strhor_paula  (strhor_paula)
  );

  // ------------------------------------------------
  // DMACON, decodes the granted register address
  dma_control dma_control_inst (
    .clk           (clk),
    .reset         (reset),
    .clk7_en       (clk7_en),
    .reg_address   (grant.reg_address), // loop back from the arbiter
    .data_in       (cpu.data),
    .blit_busy     (blit_busy),
    .blit_zero     (blit_zero),
    .enables       (enables),
    .data_out      (data_out)
  );

  // ------------------------------------------------
  // priority arbiter
  bus_arbiter #(
    .bls_cnt_max   (bls_cnt_max)
  ) bus_arbiter_inst (
    .clk           (clk),
    .clk7_en       (clk7_en),
    .cck           (cck),
    .refresh       (refresh),
    .enables       (enables),
    .bls           (bls),
    .cpu           (cpu),
    .disk          (disk),
    .audio         (audio),
    .bitplane      (bitplane),
    .sprite        (sprite),
    .copper        (copper),
    .blitter       (blitter),
    .grant         (grant),
    .ack_spr       (ack_spr),
    .ack_cop       (ack_cop),
    .ack_blt       (ack_blt),
    .ena_cop       (ena_cop),
    .ena_blt       (ena_blt)
  );

endmodule

`default_nettype wire

// File: tests/tb_agnus_bus.sv
// ------------------------------------------------
// testbench for the chip bus core: clock, reset,
// lfsr stimulus, reference model with concurrent
// checkers, watchdog and report
// ------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_agnus_bus;

  localparam int unsigned line_len    = 454;
  localparam int unsigned bls_cnt_max = 3;
  localparam int          run_cycles  = 2400; // summed test lengths in clocks
  localparam int          margin      = 600;
  localparam logic [4:0][15:0] gate_masks = {16'h0040, 16'h0080, 16'h0020, 16'h0100, 16'h0200};

  logic                     clk;
  logic                     reset;
  logic                     bls;
  logic                     blit_busy;
  logic                     blit_zero;
  agnus_pkg::cpu_bus_t      cpu;
  agnus_pkg::dma_chan_t     disk_ch;
  agnus_pkg::dma_chan_t     audio_ch;
  agnus_pkg::dma_chan_t     bpl_ch;
  agnus_pkg::dma_chan_t     spr_ch;
  agnus_pkg::dma_chan_t     cop_ch;
  agnus_pkg::dma_chan_t     blt_ch;
  agnus_pkg::bus_grant_t    grant;
  logic [15:0]              data_out;
  logic [8:0]               hpos;
  logic                     cck, sol, strhor_denise, strhor_paula;
  logic                     ack_spr, ack_cop, ack_blt, ena_cop, ena_blt;

  // ------------------------------------------------
  // reference model state
  logic [8:0]               exp_hpos;
  logic [12:0]              exp_dmacon;
  int unsigned              exp_bls_cnt;   // cpu misses seen by the slowdown rule
  logic                     exp_refresh;
  logic                     en_bpl, en_cop, en_blt, en_spr;
  logic                     slow_full;
  agnus_pkg::bus_owner_t    exp_owner;
  agnus_pkg::dma_chan_t     sel;           // fields of the winning channel
  agnus_pkg::bus_grant_t    exp_grant;
  logic [2:0]               exp_acks;      // spr, cop, blt
  logic [1:0]               exp_ena;       // cop, blt
  logic [15:0]              exp_data;
  logic [3:0]               exp_slot;      // cck, sol, denise, paula

  string                    test_name = "startup";
  int                       test_errors = 0;
  int                       total_errors = 0;
  int                       tests_run = 0;
  int                       tests_failed = 0;
  logic [31:0]              lfsr_state = 32'h6c48c791;

  agnus_bus #(
    .line_len      (line_len),
    .bls_cnt_max   (bls_cnt_max)
  ) agnus_bus_inst (
    .clk (clk), .reset (reset), .clk7_en (1'b1), .bls (bls), .cpu (cpu),
    .disk (disk_ch), .audio (audio_ch), .bitplane (bpl_ch), .sprite (spr_ch),
    .copper (cop_ch), .blitter (blt_ch), .blit_busy (blit_busy), .blit_zero (blit_zero),
    .grant (grant), .data_out (data_out), .hpos (hpos), .cck (cck), .sol (sol),
    .strhor_denise (strhor_denise), .strhor_paula (strhor_paula), .ack_spr (ack_spr),
    .ack_cop (ack_cop), .ack_blt (ack_blt), .ena_cop (ena_cop), .ena_blt (ena_blt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  // ------------------------------------------------
  // sequential part of the model
  always @(posedge clk) begin
    if (reset) begin
      exp_hpos    <= '0;
      exp_dmacon  <= '0;
      exp_bls_cnt <= 0;
    end else begin
      exp_hpos <= (exp_hpos == 9'(line_len - 1)) ? 9'd0 : exp_hpos + 9'd1;
      if (exp_grant.reg_address == agnus_pkg::reg_dmacon) begin
        exp_dmacon <= cpu.data[15] ? (exp_dmacon | cpu.data[12:0]) :
                                     (exp_dmacon & ~cpu.data[12:0]);
      end
      if (!exp_hpos[0]) begin // even slots only
        if (!bls || exp_dmacon[10]) exp_bls_cnt <= 0;
        else if (exp_bls_cnt < bls_cnt_max) exp_bls_cnt <= exp_bls_cnt + 1;
      end
    end
  end

  // combinational part, lowest priority first so higher ones override
  always_comb begin
    exp_refresh = exp_hpos inside {9'd1, 9'd3, 9'd5, 9'd7};
    en_bpl      = exp_dmacon[9] & exp_dmacon[8];
    en_cop      = exp_dmacon[9] & exp_dmacon[7];
    en_blt      = exp_dmacon[9] & exp_dmacon[6];
    en_spr      = exp_dmacon[9] & exp_dmacon[5];
    slow_full   = (exp_bls_cnt >= bls_cnt_max);
    exp_owner   = agnus_pkg::cpu;
    if (blt_ch.req && en_blt && !slow_full) exp_owner = agnus_pkg::blitter;
    if (cop_ch.req && en_cop) exp_owner = agnus_pkg::copper;
    if (spr_ch.req && en_spr) exp_owner = agnus_pkg::sprite;
    if (bpl_ch.req && en_bpl) exp_owner = agnus_pkg::bitplane;
    if (audio_ch.req) exp_owner = agnus_pkg::audio;
    if (exp_refresh) exp_owner = agnus_pkg::refresh;
    if (disk_ch.req) exp_owner = agnus_pkg::disk;
    sel = '{req: 1'b0, we: 1'b0, address: '0, reg_address: agnus_pkg::reg_idle};
    case (exp_owner)
      agnus_pkg::disk:     sel = disk_ch;
      agnus_pkg::audio:    sel = audio_ch;
      agnus_pkg::bitplane: sel = bpl_ch;
      agnus_pkg::sprite:   sel = spr_ch;
      agnus_pkg::copper:   sel = cop_ch;
      agnus_pkg::blitter:  sel = blt_ch;
      agnus_pkg::cpu:      if (cpu.aen && (cpu.rd || cpu.hwr || cpu.lwr)) sel.reg_address = cpu.address;
      default:             ; // refresh keeps the idle read
    endcase
    exp_grant.owner       = exp_owner;
    exp_grant.address     = sel.address;
    exp_grant.reg_address = sel.reg_address;
    exp_grant.dbr         = (exp_owner != agnus_pkg::cpu);
    exp_grant.dbwe        = sel.we && (exp_owner inside {agnus_pkg::disk, agnus_pkg::blitter});
    exp_grant.cpu_custom  = (exp_owner == agnus_pkg::cpu);
    exp_acks = {exp_owner == agnus_pkg::sprite, exp_owner == agnus_pkg::copper,
                exp_owner == agnus_pkg::blitter};
    exp_ena[1] = !(bpl_ch.req && en_bpl);
    exp_ena[0] = !(disk_ch.req || exp_refresh || audio_ch.req || (bpl_ch.req && en_bpl) ||
                   (spr_ch.req && en_spr) || (cop_ch.req && en_cop)) && !slow_full;
    exp_data = (exp_grant.reg_address == agnus_pkg::reg_dmaconr) ?
               {1'b0, blit_busy, blit_zero, exp_dmacon} : 16'h0000;
    exp_slot = {exp_hpos[0], exp_hpos == 9'(line_len - 1), exp_hpos == 9'd11, exp_hpos == 9'd13};
  end

  // ------------------------------------------------
  // checkers
  grant_owner_chk: assert property (@(posedge clk) disable iff (reset)
    grant.owner == exp_grant.owner)
    else report_mismatch("grant owner", $sampled(exp_grant.owner), $sampled(grant.owner));
  grant_addr_chk: assert property (@(posedge clk) disable iff (reset)
    grant.address == exp_grant.address)
    else report_mismatch("grant address", $sampled(exp_grant.address), $sampled(grant.address));
  grant_reg_chk: assert property (@(posedge clk) disable iff (reset)
    grant.reg_address == exp_grant.reg_address)
    else report_mismatch("reg address", $sampled(exp_grant.reg_address),
      $sampled(grant.reg_address));
  grant_flag_chk: assert property (@(posedge clk) disable iff (reset)
    {grant.dbr, grant.dbwe, grant.cpu_custom} ==
    {exp_grant.dbr, exp_grant.dbwe, exp_grant.cpu_custom})
    else report_mismatch("dbr/dbwe/cpu_custom",
      $sampled({exp_grant.dbr, exp_grant.dbwe, exp_grant.cpu_custom}),
      $sampled({grant.dbr, grant.dbwe, grant.cpu_custom}));
  ack_chk: assert property (@(posedge clk) disable iff (reset)
    {ack_spr, ack_cop, ack_blt} == exp_acks)
    else report_mismatch("acks", $sampled(exp_acks), $sampled({ack_spr, ack_cop, ack_blt}));
  ena_chk: assert property (@(posedge clk) disable iff (reset) {ena_cop, ena_blt} == exp_ena)
    else report_mismatch("ena_cop/ena_blt", $sampled(exp_ena), $sampled({ena_cop, ena_blt}));
  read_chk: assert property (@(posedge clk) disable iff (reset) data_out == exp_data)
    else report_mismatch("data_out", $sampled(exp_data), $sampled(data_out));
  hpos_chk: assert property (@(posedge clk) disable iff (reset) hpos == exp_hpos)
    else report_mismatch("hpos", $sampled(exp_hpos), $sampled(hpos));
  slot_chk: assert property (@(posedge clk) disable iff (reset)
    {cck, sol, strhor_denise, strhor_paula} == exp_slot)
    else report_mismatch("cck/sol/strobes", $sampled(exp_slot),
      $sampled({cck, sol, strhor_denise, strhor_paula}));

  task automatic report_mismatch(input string what, input logic [32:0] exp, input logic [32:0] act);
    $display("Error: test %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
    test_errors++;
  endtask

  // ------------------------------------------------
  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic agnus_pkg::dma_chan_t random_chan(input logic req);
    agnus_pkg::dma_chan_t c;
    c.req         = req;
    c.we          = take_bits(1);
    c.address     = take_bits(20);
    c.reg_address = 8'h80 | 8'(take_bits(7)); // upper half, never DMACON or DMACONR
    return c;
  endfunction

  task automatic next_cycle;
    @(posedge clk);
    #1; // inputs move just after the edge
  endtask

  task automatic idle_inputs;
    cpu      = '0;
    disk_ch  = '0;
    audio_ch = '0;
    bpl_ch   = '0;
    spr_ch   = '0;
    cop_ch   = '0;
    blt_ch   = '0;
  endtask

  task automatic apply_reset;
    reset = 1'b1;
    bls   = 1'b0; // lets the slowdown counter clear
    idle_inputs();
    repeat (16) next_cycle();
    reset = 1'b0;
  endtask

  // held two slots so a refresh slot cannot swallow it
  task automatic cpu_write(input logic [15:0] value);
    cpu = '{aen: 1'b1, rd: 1'b0, hwr: 1'b1, lwr: 1'b1,
            address: agnus_pkg::reg_dmacon, data: value};
    repeat (2) next_cycle();
    cpu = '0;
  endtask

  task automatic cpu_read(input logic [7:0] addr);
    cpu       = '{aen: 1'b1, rd: 1'b1, hwr: 1'b0, lwr: 1'b0, address: addr, data: 16'h0000};
    blit_busy = take_bits(1);
    blit_zero = take_bits(1);
    next_cycle();
    cpu = '0;
  endtask

  task automatic random_requests(input logic use_disk);
    logic [5:0] mask;
    mask = take_bits(6);
    if (take_bits(2) == 0) mask = '0; // some free slots for the cpu
    disk_ch  = random_chan(mask[0] & use_disk);
    audio_ch = random_chan(mask[1]);
    bpl_ch   = random_chan(mask[2]);
    spr_ch   = random_chan(mask[3]);
    cop_ch   = random_chan(mask[4]);
    blt_ch   = random_chan(mask[5]);
    cpu = '{aen: take_bits(1), rd: take_bits(1), hwr: take_bits(1), lwr: take_bits(1),
            address: take_bits(8), data: 16'h0000}; // zero data leaves DMACON alone
    next_cycle();
  endtask

  task automatic wait_ack_blt(input logic level, input int limit);
    int n;
    n = 0;
    while (ack_blt !== level && n < limit) begin
      next_cycle();
      n++;
    end
    if (ack_blt !== level) begin
      $display("Error: test %s, ack_blt did not go to %0d within %0d cycles",
               test_name, level, limit);
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test;
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) tests_failed++;
    $display("test %-16s %s (%0d errors)", test_name,
             (test_errors == 0) ? "ok" : "FAILED", test_errors);
  endtask

  // ------------------------------------------------
  // stimulus
  initial begin
    logic [7:0] addr;
    blit_busy = 1'b0;
    blit_zero = 1'b0;
    apply_reset();

    begin_test("register access");
    repeat (48) begin
      cpu_write(16'(take_bits(16)));
      cpu_read(agnus_pkg::reg_dmaconr);
      addr = take_bits(8);
      if (addr == agnus_pkg::reg_dmaconr || addr == agnus_pkg::reg_dmacon) addr = addr ^ 8'h80;
      cpu_read(addr); // wrong address reads zero
    end
    end_test();

    begin_test("priority");
    cpu_write(16'h83e0); // master, bitplane, copper, blitter, sprite
    repeat (400) random_requests(1'b1);
    idle_inputs();
    end_test();

    begin_test("enable gating");
    for (int k = 0; k < 5; k++) begin
      cpu_write(gate_masks[k]);
      repeat (60) random_requests(1'b1);
      idle_inputs();
      cpu_write(16'h8000 | gate_masks[k]);
    end
    end_test();

    begin_test("blitter slowdown");
    cpu_write(16'h0400); // bltpri off
    blt_ch = random_chan(1'b1);
    bls    = 1'b1;
    wait_ack_blt(1'b0, 40);
    repeat (10) next_cycle();
    bls = 1'b0;
    wait_ack_blt(1'b1, 40);
    repeat (6) next_cycle();
    bls = 1'b1;
    wait_ack_blt(1'b0, 40);
    cpu_write(16'h8400); // cpu gets in while the blitter is held off
    wait_ack_blt(1'b1, 40);
    repeat (10) next_cycle();
    idle_inputs();
    bls = 1'b0;
    cpu_write(16'h0400);
    end_test();

    begin_test("slot timing");
    apply_reset();
    cpu_write(16'h83e0);
    repeat (2 * line_len + 12) random_requests(1'b0); // no disk so refresh shows
    idle_inputs();
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // ------------------------------------------------
  // watchdog
  initial begin
    #((run_cycles + margin) * 10);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
src/agnus_pkg.sv
src/beam_timer.sv
src/dma_control.sv
src/bus_arbiter.sv
src/agnus_bus.sv
tests/tb_agnus_bus.sv
